/* common/card_link_defines.svh */
/*
 * Card link constants.
 * Field positions of a received link byte, the command codes,
 * the bust limit and the tags carried in the top bits of a reply byte.
 */

`ifndef CARD_LINK_DEFINES_SVH
`define CARD_LINK_DEFINES_SVH

// a set flag bit marks a card byte, a clear one a command byte.
`define CARD_FLAG_BIT 7
`define OWNER_BIT     6

`define CMD_START     3'd1
`define CMD_STAND     3'd2
`define CMD_REPORT    3'd3

`define BUST_LIMIT    5'd21

`define TAG_PLAYER    2'b01
`define TAG_DEALER    2'b10
`define TAG_OUTCOME   2'b11

`endif

/* common/card_link_pkg.sv */
/*
 * Card link types.
 * The received byte with its card and command views, the decoded item
 * passed to the hand tally, and the result event passed to the encoder.
 */

package card_link_pkg;

    // card byte: flag, owner (1 = dealer), two spare bits, rank 1..13.
    typedef struct packed {
        logic       flag;
        logic       owner;
        logic [1:0] spare;
        logic [3:0] rank;
    } card_field_t;

    // command byte: flag, four spare bits, command code.
    typedef struct packed {
        logic       flag;
        logic [3:0] spare;
        logic [2:0] code;
    } cmd_field_t;

    typedef union packed {
        card_field_t card;
        cmd_field_t  cmd;
    } link_byte_u;

    typedef enum logic {
        CARD    = 1'b0,
        COMMAND = 1'b1
    } item_kind_e;

    typedef struct packed {
        logic       valid;
        item_kind_e kind;
        logic       owner;
        logic [3:0] rank;
        logic [2:0] cmd;
    } link_item_t;

    typedef enum logic [2:0] {
        PLAYER_BUST = 3'd0,
        DEALER_BUST = 3'd1,
        PLAYER_WIN  = 3'd2,
        DEALER_WIN  = 3'd3,
        PUSH        = 3'd4
    } outcome_e;

    typedef enum logic {
        OUTCOME = 1'b0,
        REPORT  = 1'b1
    } result_kind_e;

    typedef struct packed {
        logic         valid;
        result_kind_e kind;
        logic [4:0]   player_total;
        logic [4:0]   dealer_total;
        outcome_e     outcome;
    } result_evt_t;

endpackage

/* link/link_decoder.sv */
/*
 * Link decoder.
 * Pops bytes from the receive FIFO and decodes each one as a card for
 * the player or dealer, or as a command. Unknown commands are dropped.
 * A command pop is followed by one idle cycle so its reply can raise busy.
 */

`timescale 1ns/1ps

`include "card_link_defines.svh"

module link_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                read_data,
    input  logic                      rx_empty,
    input  logic                      busy,
    output logic                      rd_uart,
    output card_link_pkg::link_item_t item
);

    card_link_pkg::link_byte_u head;
    card_link_pkg::link_item_t item_nxt;
    logic                      hold;
    logic                      is_card;
    logic                      cmd_known;

    assign head    = read_data;
    assign is_card = read_data[`CARD_FLAG_BIT];

    // hold is set in reset as well, so nothing is popped before release.
    assign rd_uart = !rx_empty && !busy && !hold;

    always_comb begin
        cmd_known = (head.cmd.code == `CMD_START) ||
                    (head.cmd.code == `CMD_STAND) ||
                    (head.cmd.code == `CMD_REPORT);
        item_nxt = '0;

        if (rd_uart) begin
            if (is_card) begin
                item_nxt.valid = 1'b1;
                item_nxt.kind  = card_link_pkg::CARD;
                item_nxt.owner = read_data[`OWNER_BIT];
                item_nxt.rank  = head.card.rank;
            end else if (cmd_known) begin
                item_nxt.valid = 1'b1;
                item_nxt.kind  = card_link_pkg::COMMAND;
                item_nxt.cmd   = head.cmd.code;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            item <= '0;
            hold <= 1'b1;
        end else begin
            item <= item_nxt;
            // every command byte, known or not, costs one idle cycle.
            hold <= rd_uart && !is_card;
        end
    end

endmodule

/* link/hand_tally.sv */
/*
 * Hand tally.
 * Keeps a hard sum and an ace flag for the player and the dealer hand.
 * Reports soft totals, or the outcome of a stand, one cycle after the
 * command item arrives.
 */

`timescale 1ns/1ps

`include "card_link_defines.svh"

module hand_tally (
    input  logic                       clk,
    input  logic                       rst,
    input  card_link_pkg::link_item_t  item,
    output card_link_pkg::result_evt_t result
);

    typedef struct packed {
        logic [4:0] hard;
        logic       ace;
    } hand_t;

    hand_t                   player;
    hand_t                   dealer;
    logic [4:0]              player_total;
    logic [4:0]              dealer_total;
    card_link_pkg::outcome_e outcome;

    function automatic logic [4:0] card_value(input logic [3:0] rank);
        if (rank == 4'd1) begin
            return 5'd1;
        end
        if (rank >= 4'd11) begin
            return 5'd10;
        end
        return {1'b0, rank};
    endfunction

    // the hard sum saturates at 31, which is a bust either way.
    function automatic hand_t add_card(input hand_t hand, input logic [3:0] rank);
        logic [5:0] sum;
        hand_t      next;
        sum       = {1'b0, hand.hard} + {1'b0, card_value(rank)};
        next.hard = sum[5] ? 5'd31 : sum[4:0];
        next.ace  = hand.ace || (rank == 4'd1);
        return next;
    endfunction

    // one ace counts as eleven when that keeps the hand in range.
    function automatic logic [4:0] soft_total(input hand_t hand);
        logic [5:0] raised;
        raised = {1'b0, hand.hard} + 6'd10;
        if (hand.ace && raised <= {1'b0, `BUST_LIMIT}) begin
            return raised[4:0];
        end
        return hand.hard;
    endfunction

    assign player_total = soft_total(player);
    assign dealer_total = soft_total(dealer);

    always_comb begin
        if (player_total > `BUST_LIMIT) begin
            outcome = card_link_pkg::PLAYER_BUST;
        end else if (dealer_total > `BUST_LIMIT) begin
            outcome = card_link_pkg::DEALER_BUST;
        end else if (player_total > dealer_total) begin
            outcome = card_link_pkg::PLAYER_WIN;
        end else if (player_total < dealer_total) begin
            outcome = card_link_pkg::DEALER_WIN;
        end else begin
            outcome = card_link_pkg::PUSH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            player <= '0;
            dealer <= '0;
            result <= '0;
        end else begin
            result.valid        <= 1'b0;
            result.player_total <= player_total;
            result.dealer_total <= dealer_total;
            result.outcome      <= outcome;

            if (item.valid && item.kind == card_link_pkg::CARD) begin
                if (item.owner) begin
                    dealer <= add_card(dealer, item.rank);
                end else begin
                    player <= add_card(player, item.rank);
                end
            end else if (item.valid) begin
                case (item.cmd)
                    `CMD_START: begin
                        player <= '0;
                        dealer <= '0;
                    end
                    `CMD_STAND: begin
                        result.valid <= 1'b1;
                        result.kind  <= card_link_pkg::OUTCOME;
                    end
                    `CMD_REPORT: begin
                        result.valid <= 1'b1;
                        result.kind  <= card_link_pkg::REPORT;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* link/link_encoder.sv */
/*
 * Link encoder.
 * Turns a result event into one outcome byte or two total bytes and
 * writes them to the transmit FIFO, one per cycle while it is not full.
 */

`timescale 1ns/1ps

`include "card_link_defines.svh"

module link_encoder (
    input  logic                       clk,
    input  logic                       rst,
    input  card_link_pkg::result_evt_t result,
    input  logic                       tx_full,
    output logic                       busy,
    output logic                       wr_uart,
    output logic [7:0]                 w_data
);

    logic [1:0][7:0] reply;
    logic [1:0]      count;
    logic [7:0]      first_byte;
    logic [7:0]      second_byte;
    logic            is_report;

    assign is_report = (result.kind == card_link_pkg::REPORT);

    always_comb begin
        if (is_report) begin
            first_byte  = {`TAG_PLAYER, 1'b0, result.player_total};
            second_byte = {`TAG_DEALER, 1'b0, result.dealer_total};
        end else begin
            first_byte  = {`TAG_OUTCOME, 3'b000, result.outcome};
            second_byte = 8'h00;
        end
    end

    // the event itself counts as busy, so the decoder stops in that cycle.
    assign busy    = result.valid || (count != 2'd0);
    assign wr_uart = (count != 2'd0) && !tx_full;
    assign w_data  = reply[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 2'd0;
        end else if (result.valid) begin
            count <= is_report ? 2'd2 : 2'd1;
        end else if (wr_uart) begin
            count <= count - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (result.valid) begin
            reply[0] <= first_byte;
            reply[1] <= second_byte;
        end else if (wr_uart) begin
            reply[0] <= reply[1];
        end
    end

endmodule

/* hdl/card_link_top.sv */
/*
 * Card link top level.
 * Connects the link decoder, the hand tally and the link encoder
 * between the receive and transmit FIFO ports.
 */

`timescale 1ns/1ps

module card_link_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] read_data,
    input  logic       rx_empty,
    output logic       rd_uart,
    input  logic       tx_full,
    output logic       wr_uart,
    output logic [7:0] w_data
);

    card_link_pkg::link_item_t  item;
    card_link_pkg::result_evt_t result;
    logic                       busy;

    link_decoder u_link_decoder (
        .clk,
        .rst,
        .read_data,
        .rx_empty,
        .busy,
        .rd_uart,
        .item
    );

    hand_tally u_hand_tally (
        .clk,
        .rst,
        .item,
        .result
    );

    link_encoder u_link_encoder (
        .clk,
        .rst,
        .result,
        .tx_full,
        .busy,
        .wr_uart,
        .w_data
    );

endmodule

/* bench/card_link_chk.sv */
/*
 * Card link checker.
 * Assertions on the FIFO strobes, the command cooldown and the
 * encoder busy level, bound into the top level.
 */

`timescale 1ns/1ps

`include "card_link_defines.svh"

module card_link_chk (
    input logic                       clk,
    input logic                       rst,
    input logic [7:0]                 read_data,
    input logic                       rx_empty,
    input logic                       rd_uart,
    input logic                       tx_full,
    input logic                       wr_uart,
    input logic                       busy,
    input card_link_pkg::result_evt_t result
);

    // a write into a full transmit FIFO would lose the byte.
    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        !(wr_uart && tx_full))
        else $error("wr_uart is high while tx_full is high");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        !(rd_uart && rx_empty))
        else $error("rd_uart is high while rx_empty is high");

    // the cycle after a command pop lets the reply raise busy.
    idle_after_command: assert property (@(posedge clk) disable iff (rst)
        (rd_uart && !read_data[`CARD_FLAG_BIT]) |=> !rd_uart)
        else $error("a byte was popped right after a command byte");

    busy_after_result: assert property (@(posedge clk) disable iff (rst)
        result.valid |=> busy)
        else $error("busy is low in the cycle after a result event");

endmodule

bind card_link_top card_link_chk card_link_chk_i (
    .clk,
    .rst,
    .read_data,
    .rx_empty,
    .rd_uart,
    .tx_full,
    .wr_uart,
    .busy,
    .result
);

/* bench/card_link_tb.sv */
/*
 * Card link testbench.
 * Models the receive and transmit FIFOs at the DUT ports, feeds the byte
 * blocks from the pattern file and compares every reply byte in order.
 * tx_full is randomized each cycle to stall the encoder.
 */

`timescale 1ns/1ps

module card_link_tb;

    logic       clk;
    logic       rst;
    logic [7:0] read_data;
    logic       rx_empty;
    logic       rd_uart;
    logic       tx_full;
    logic       wr_uart;
    logic [7:0] w_data;

    logic [7:0] rx_fifo[$];
    logic [7:0] expect_q[$];
    logic [7:0] rx_bytes[$];
    logic [7:0] tx_bytes[$];
    string      test_names[$];
    int         rx_start[$];
    int         rx_counts[$];
    int         tx_start[$];
    int         tx_counts[$];

    logic       pop_seen;
    int         limit_cycles;
    int         error_count;
    int         test_errors;
    int         pass_count;
    int         fail_count;

    card_link_top card_link_top_i (
        .clk,
        .rst,
        .read_data,
        .rx_empty,
        .rd_uart,
        .tx_full,
        .wr_uart,
        .w_data
    );

    always #10 clk = ~clk;

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %02h, expected %02h",
                     $time, what, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic take_reply(input logic [7:0] data);
        logic [7:0] expected;
        if (expect_q.size() == 0) begin
            $display("unexpected reply byte %02h at %0t while no reply was pending",
                     data, $time);
            error_count++;
            test_errors++;
        end else begin
            expected = expect_q.pop_front();
            check_value(data, expected, "reply byte");
        end
    endtask

    task automatic load_patterns();
        int         fd;
        int         code;
        int         last;
        string      tok;
        string      rest;
        string      mode;
        logic [7:0] value;
        fd = $fopen("bench/card_link_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file bench/card_link_patterns.txt");
            error_count++;
            return;
        end
        mode = "";
        while ($fscanf(fd, "%s", tok) == 1) begin
            last = test_names.size() - 1;
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "test") begin
                code = $fscanf(fd, "%s", tok);
                test_names.push_back(tok);
                rx_start.push_back(rx_bytes.size());
                tx_start.push_back(tx_bytes.size());
                rx_counts.push_back(0);
                tx_counts.push_back(0);
                mode = "";
            end else if (tok == "rx" || tok == "tx") begin
                mode = tok;
            end else if (tok == "end") begin
                mode = "";
            end else if (mode == "" || last < 0 || $sscanf(tok, "%h", value) != 1) begin
                $display("the pattern file holds a stray token %s", tok);
                error_count++;
            end else if (mode == "rx") begin
                rx_bytes.push_back(value);
                rx_counts[last]++;
            end else begin
                tx_bytes.push_back(value);
                tx_counts[last]++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        test_errors = 0;
        for (int i = 0; i < tx_counts[t]; i++) begin
            expect_q.push_back(tx_bytes[tx_start[t] + i]);
        end
        for (int i = 0; i < rx_counts[t]; i++) begin
            rx_fifo.push_back(rx_bytes[rx_start[t] + i]);
        end
        while (rx_fifo.size() != 0 || expect_q.size() != 0) begin
            @(posedge clk);
        end
        // a few quiet cycles, so a stray reply is charged to this test.
        repeat (8) @(posedge clk);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: passed", test_names[t]);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", test_names[t], test_errors);
        end
    endtask

    // FIFO models. Inputs change on the falling edge, and the strobes are
    // sampled 1 ns later, where they hold until the next rising edge.
    always @(negedge clk) begin
        if (pop_seen) begin
            void'(rx_fifo.pop_front());
        end
        if (rx_fifo.size() != 0) begin
            read_data <= rx_fifo[0];
            rx_empty  <= 1'b0;
        end else begin
            read_data <= 8'h00;
            rx_empty  <= 1'b1;
        end
        tx_full <= ($urandom % 3) == 0;
        #1;
        pop_seen = rd_uart;
        if (wr_uart) begin
            take_reply(w_data);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h13ca));
        clk          = 1'b0;
        rst          = 1'b1;
        read_data    = 8'h00;
        rx_empty     = 1'b1;
        tx_full      = 1'b0;
        pop_seen     = 1'b0;
        error_count  = 0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        limit_cycles = 0;

        load_patterns();
        limit_cycles = 200 * (rx_bytes.size() + tx_bytes.size()) + 20;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;

        for (int t = 0; t < test_names.size(); t++) begin
            run_test(t);
        end
        if (test_names.size() == 0) begin
            $display("no test blocks were found in the pattern file");
            error_count++;
        end

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* bench/card_link_patterns.txt */
# test <name> opens a block, rx lists the bytes sent, tx the reply bytes expected, end closes it.
# hex bytes: 8r player card, cr dealer card (rank r = 1..d), 01 start, 02 stand, 03 report.
test report_numbers
rx 01 85 87 c9 c4 03
tx 4c 8d
end
test ace_soft
rx 01 81 86 c1 c1 03 8d 03
tx 51 8c 51 8c
end
test player_bust
rx 01 8a 8d 85 cd cc c5 02
tx c0
end
test dealer_bust
rx 01 89 88 ca c6 cb 02
tx c1
end
test player_win
rx 01 81 89 ca c8 02
tx c2
end
test dealer_win
rx 01 8a 87 c1 cc 02
tx c3
end
test push
rx 01 8a 89 c5 c4 cd 02
tx c4
end
test start_clears
rx 01 89 c9 8c 01 82 c3 03
tx 42 83
end
test unknown_commands
rx 01 84 00 05 c6 07 03 04 06
tx 44 86
end
test reply_stream
rx 01 8a 03 c7 03 88 02 03 c5 c6 02 03 03
tx 4a 80 4a 87 c2 52 87 c4 52 92 52 92
end

/* project.f */
+incdir+common
common/card_link_pkg.sv
link/link_decoder.sv
link/hand_tally.sv
link/link_encoder.sv
hdl/card_link_top.sv
bench/card_link_chk.sv
bench/card_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the card link testbench with Verilator, run it and search its output
# for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module card_link_tb \
    -o card_link_sim || { echo "build failed"; exit 1; }
output=$(./obj_dir/card_link_sim)
echo "$output"
echo "$output" | grep -q -x -F '>>> PASS' && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
